// ==== rtl/board_config.svh ====
/*
 * board-level constants for the parameter block
 * version words, watchdog prescale, motor-voltage settle count, axis count
 */

`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ------------------------------------------------------------
// identification
// ------------------------------------------------------------
`define BOARD_VERSION 32'h514C4131   // "QLA1" in ascii
`define FW_VERSION    32'h00000003   // firmware revision

// ------------------------------------------------------------
// axes and timing
// ------------------------------------------------------------
`define NUM_AXES 4                   // amplifier channels on the board

// sysclk cycles per watchdog tick
// kept tiny so simulation reaches a timeout quickly
`define WDOG_PRESCALE 16'd4

// ticks that mv_good must hold before amps may enable
`define MV_SETTLE_TICKS 16'd8

`endif

// ==== rtl/host_bus_pkg.sv ====
/*
 * host register bus types
 * request payload and the single-cycle register access
 */

`default_nettype none

package host_bus_pkg;

    // one host transaction as held on host_cmd
    typedef struct packed {
        logic        wr;      // 1 = write, 0 = read
        logic [7:0]  addr;    // register address
        logic [31:0] wdata;   // write data, ignored on reads
    } host_req_t;

    // strobe is high for exactly one sysclk per handshake
    typedef struct packed {
        logic      strobe;
        host_req_t req;
    } reg_access_t;

endpackage

`default_nettype wire

// ==== rtl/board_reg_pkg.sv ====
/*
 * board register map and pin images
 * address enum, board in/out structs, status word union, safety feedback
 */

`default_nettype none

`include "board_config.svh"

package board_reg_pkg;

    // ------------------------------------------------------------
    // register map, channel 0 only
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        REG_STATUS     = 4'd0,   // status / command
        REG_PHYCTRL    = 4'd1,   // phy request scratch
        REG_PHYDATA    = 4'd2,   // phy data scratch
        REG_TIMEOUT    = 4'd3,   // watchdog period
        REG_VERSION    = 4'd4,   // board version, read only
        REG_TEMPSNS    = 4'd5,   // temperature sensors
        REG_DIGIOUT    = 4'd6,   // digital outputs, masked
        REG_FW_VERSION = 4'd7,   // firmware version, read only
        REG_DIGIN      = 4'd10,  // limits, home, v_fault
        REG_SAFETY     = 4'd11,  // external safety disables
        REG_WDOG       = 4'd14,  // watchdog disables
        REG_AMPDIS     = 4'd15   // final amp disable vector
    } reg_addr_e;

    // pins coming into the board
    typedef struct packed {
        logic [`NUM_AXES-1:0] neg_limit;
        logic [`NUM_AXES-1:0] pos_limit;
        logic [`NUM_AXES-1:0] home;
        logic [`NUM_AXES-1:0] fault;
        logic                 relay;      // safety relay contact
        logic                 mv_good;    // motor voltage good
        logic                 v_fault;
        logic [3:0]           board_id;   // rotary switch
        logic [15:0]          temp_sense;
    } board_in_t;

    // pins driven out of the board
    typedef struct packed {
        logic [`NUM_AXES-1:0] amp_disable;
        logic [`NUM_AXES-1:0] dout;
        logic                 pwr_enable;
        logic                 relay_on;
    } board_out_t;

    // ------------------------------------------------------------
    // REG_STATUS, written as a command and read as a status
    // ------------------------------------------------------------
    typedef struct packed {
        logic [11:0] rsvd3;
        logic        pwr_mask;    // bit 19
        logic        pwr_val;     // bit 18
        logic        relay_mask;  // bit 17
        logic        relay_val;   // bit 16
        logic [3:0]  rsvd2;
        logic [3:0]  en_mask;     // bits 11..8
        logic [3:0]  rsvd1;
        logic [3:0]  en_val;      // bits 3..0
    } status_cmd_t;

    typedef struct packed {
        logic [3:0] num_axes;      // 31..28
        logic [3:0] board_id;      // 27..24
        logic       wdog_timeout;  // 23
        logic [2:0] rsvd1;
        logic       mv_good;       // 19
        logic       pwr_enable;    // 18
        logic       relay_n;       // 17, inverted relay contact
        logic       relay_on;      // 16
        logic [3:0] rsvd0;
        logic [3:0] fault;         // 11..8
        logic [3:0] safety_in;     // 7..4
        logic [3:0] amp_en;        // 3..0
    } status_rd_t;

    typedef union packed {
        status_cmd_t cmd;
        status_rd_t  rd;
    } status_word_u;

    // fed back from amp_safety to the register file
    typedef struct packed {
        logic                 wdog_timeout;
        logic [`NUM_AXES-1:0] wdog_disable;
        logic [`NUM_AXES-1:0] mv_disable;
    } safety_state_t;

endpackage

`default_nettype wire

// ==== rtl/host_bus_port.sv ====
/*
 * host bus slave, four-phase req/ack
 * turns each handshake into one register access and returns read data
 */

`timescale 1ns/1ns
`default_nettype none

module host_bus_port (
    input  logic                      sysclk,
    input  logic                      reset,       // sync, active low
    input  logic                      host_req,
    input  host_bus_pkg::host_req_t   host_cmd,
    output logic                      host_ack,
    output logic [31:0]               host_rdata,
    output host_bus_pkg::reg_access_t access,
    input  logic [31:0]               rdata        // from register file, 1 cycle late
);
    import host_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for req
        ST_ACCESS,   // strobe out this cycle
        ST_ACK       // capture data, raise ack, wait for req low
    } state_e;

    state_e    state;
    logic      strobe_q;
    host_req_t cmd_q;   // command latched at req

    assign access = '{strobe: strobe_q, req: cmd_q};

    // ------------------------------------------------------------
    // handshake FSM
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state    <= ST_IDLE;
            strobe_q <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            strobe_q <= 1'b0;   // one cycle only
            case (state)
                ST_IDLE: if (host_req) begin
                    state    <= ST_ACCESS;
                    strobe_q <= 1'b1;
                end
                ST_ACCESS: state <= ST_ACK;   // regs answer now
                ST_ACK: begin
                    if (!host_ack) begin
                        host_ack <= 1'b1;
                    end else if (!host_req) begin   // phase 3 seen
                        host_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload regs
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && host_req)
            cmd_q <= host_cmd;
        if (state == ST_ACK && !host_ack)
            host_rdata <= rdata;   // held while ack is high
    end

    // ack may only rise in answer to a live request
    a_ack_needs_req: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(host_ack) |-> host_req && $past(host_req));

endmodule

`default_nettype wire

// ==== rtl/board_regs.sv ====
/*
 * board register file
 * masked command writes, read mux, sticky per-axis disables
 */

`timescale 1ns/1ns
`default_nettype none

`include "board_config.svh"

module board_regs (
    input  logic                         sysclk,
    input  logic                         reset,
    input  host_bus_pkg::reg_access_t    access,
    output logic [31:0]                  rdata,
    input  board_reg_pkg::board_in_t     board_in,
    input  logic [3:0]                   safety_amp_disable,  // external safety chain
    input  board_reg_pkg::safety_state_t safety,
    output logic                         wr_strobe,
    output logic [15:0]                  wdog_period,
    output logic [3:0]                   sw_disable,
    output logic [3:0]                   dout,
    output logic                         pwr_enable,
    output logic                         relay_on
);
    import board_reg_pkg::*;

    reg_addr_e    addr_e;
    logic         mapped;     // only channel 0 lives here
    logic         wr_en;
    logic         rd_en;
    status_word_u wr_word;    // command view of wdata
    status_word_u rd_word;    // status view for reads
    logic [3:0]   dis_next;
    logic [3:0]   amp_disable;
    logic [15:0]  phy_ctrl;
    logic [15:0]  phy_data;
    logic [31:0]  rd_mux;

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    assign addr_e    = reg_addr_e'(access.req.addr[3:0]);
    assign mapped    = (access.req.addr[7:4] == 4'd0);
    assign wr_strobe = access.strobe && access.req.wr;   // any write kicks the watchdog
    assign wr_en     = wr_strobe && mapped;
    assign rd_en     = access.strobe && !access.req.wr;
    assign wr_word   = access.req.wdata;

    assign amp_disable = sw_disable | safety.mv_disable;   // same as the pin vector

    // sticky disables
    always_comb begin
        dis_next = sw_disable;
        if (wr_en && addr_e == REG_STATUS)   // masked enable, 1 = enable
            dis_next = (sw_disable & ~wr_word.cmd.en_mask)
                     | (~wr_word.cmd.en_val & wr_word.cmd.en_mask);
        dis_next = dis_next | safety.wdog_disable | safety_amp_disable;
        if (!pwr_enable)
            dis_next = '1;   // no enables without motor power
    end

    // ------------------------------------------------------------
    // writable registers
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            sw_disable  <= '1;   // all axes off
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            dout        <= '0;
            phy_ctrl    <= '0;
            phy_data    <= '0;
            wdog_period <= '1;   // watchdog effectively off
        end else begin
            sw_disable <= dis_next;
            if (wr_en) begin
                case (addr_e)
                    REG_STATUS: begin
                        if (wr_word.cmd.relay_mask) relay_on   <= wr_word.cmd.relay_val;
                        if (wr_word.cmd.pwr_mask)   pwr_enable <= wr_word.cmd.pwr_val;
                    end
                    REG_PHYCTRL: phy_ctrl    <= access.req.wdata[15:0];
                    REG_PHYDATA: phy_data    <= access.req.wdata[15:0];
                    REG_TIMEOUT: wdog_period <= access.req.wdata[15:0];
                    REG_DIGIOUT:   // value 3..0, mask 11..8
                        dout <= (dout & ~access.req.wdata[11:8])
                              | (access.req.wdata[3:0] & access.req.wdata[11:8]);
                    default: ;   // read only / unmapped
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // read side
    // ------------------------------------------------------------
    always_comb begin
        rd_word.rd = '{
            num_axes:     4'(`NUM_AXES),
            board_id:     board_in.board_id,
            wdog_timeout: safety.wdog_timeout,
            rsvd1:        '0,
            mv_good:      board_in.mv_good,
            pwr_enable:   pwr_enable,
            relay_n:      ~board_in.relay,
            relay_on:     relay_on,
            rsvd0:        '0,
            fault:        board_in.fault,
            safety_in:    safety_amp_disable,
            amp_en:       ~sw_disable
        };
    end

    always_comb begin
        case (addr_e)
            REG_STATUS:     rd_mux = rd_word;
            REG_PHYCTRL:    rd_mux = 32'(phy_ctrl);
            REG_PHYDATA:    rd_mux = 32'(phy_data);
            REG_TIMEOUT:    rd_mux = 32'(wdog_period);
            REG_VERSION:    rd_mux = `BOARD_VERSION;
            REG_TEMPSNS:    rd_mux = 32'(board_in.temp_sense);
            REG_DIGIOUT:    rd_mux = 32'(dout);
            REG_FW_VERSION: rd_mux = `FW_VERSION;
            REG_DIGIN:      rd_mux = 32'({board_in.v_fault, dout, board_in.neg_limit,
                                          board_in.pos_limit, board_in.home});
            REG_SAFETY:     rd_mux = 32'(safety_amp_disable);
            REG_WDOG:       rd_mux = 32'(safety.wdog_disable);
            REG_AMPDIS:     rd_mux = 32'(amp_disable);
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (rd_en)
            rdata <= mapped ? rd_mux : 32'd0;   // valid the cycle after strobe
    end

    // power off must have forced every axis off by the next cycle
    a_off_when_unpowered: assert property (@(posedge sysclk) disable iff (!reset)
        $past(!pwr_enable) |-> &sw_disable);

endmodule

`default_nettype wire

// ==== rtl/amp_safety.sv ====
/*
 * amplifier safety logic
 * watchdog prescaler and timer, motor-voltage settle timer, final disable OR
 */

`timescale 1ns/1ns
`default_nettype none

`include "board_config.svh"

module amp_safety (
    input  logic                         sysclk,
    input  logic                         reset,
    input  logic                         wr_strobe,     // any host write
    input  logic [15:0]                  wdog_period,   // in ticks, 0 = off
    input  logic                         mv_good,
    input  logic [3:0]                   sw_disable,
    output board_reg_pkg::safety_state_t safety,
    output logic [3:0]                   amp_disable
);

    logic        tick;
    logic [15:0] presc_cnt;
    logic [15:0] wdog_cnt;      // ticks since last write
    logic        wdog_timeout;
    logic [3:0]  wdog_disable;
    logic [15:0] settle_cnt;    // ticks with mv_good high
    logic [3:0]  mv_disable;

    // ------------------------------------------------------------
    // tick prescaler
    // ------------------------------------------------------------
    assign tick = (presc_cnt == `WDOG_PRESCALE - 16'd1);

    always_ff @(posedge sysclk) begin
        if (!reset || tick)
            presc_cnt <= '0;
        else
            presc_cnt <= presc_cnt + 16'd1;
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset || wr_strobe) begin   // host alive
            wdog_cnt     <= '0;
            wdog_timeout <= 1'b0;
            wdog_disable <= '0;
        end else if (tick && wdog_period != 16'd0) begin
            if (wdog_cnt < wdog_period) begin
                wdog_cnt <= wdog_cnt + 16'd1;
            end else begin
                wdog_timeout <= 1'b1;   // host went quiet
                wdog_disable <= '1;
            end
        end
    end

    // motor voltage settle
    always_ff @(posedge sysclk) begin
        if (!reset || !mv_good)
            settle_cnt <= '0;
        else if (tick && settle_cnt < `MV_SETTLE_TICKS)
            settle_cnt <= settle_cnt + 16'd1;   // saturates
    end

    // immediate on mv_good low, held until settled
    assign mv_disable = (!mv_good || settle_cnt < `MV_SETTLE_TICKS) ? 4'hf : 4'h0;

    assign amp_disable = sw_disable | mv_disable;
    assign safety = '{wdog_timeout: wdog_timeout,
                      wdog_disable: wdog_disable,
                      mv_disable:   mv_disable};

    // lost motor voltage keeps amps off now and through the next cycle
    a_mv_low_disables: assert property (@(posedge sysclk) disable iff (!reset)
        !mv_good |-> &amp_disable ##1 &amp_disable);

endmodule

`default_nettype wire

// ==== rtl/board_ctrl_top.sv ====
/*
 * board parameter block top level
 * host bus port, register file, amplifier safety
 */

`timescale 1ns/1ns
`default_nettype none

module board_ctrl_top (
    input  logic                      sysclk,
    input  logic                      reset,
    input  logic                      host_req,
    input  host_bus_pkg::host_req_t   host_cmd,
    output logic                      host_ack,
    output logic [31:0]               host_rdata,
    input  board_reg_pkg::board_in_t  board_in,
    input  logic [3:0]                safety_amp_disable,
    output board_reg_pkg::board_out_t board_out
);
    import host_bus_pkg::*;
    import board_reg_pkg::*;

    reg_access_t   access;       // one strobe per handshake
    logic [31:0]   rdata;
    safety_state_t safety;
    logic          wr_strobe;
    logic [15:0]   wdog_period;
    logic [3:0]    sw_disable;

    host_bus_port host_bus_port_i (
        .sysclk     (sysclk),
        .reset      (reset),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .access     (access),
        .rdata      (rdata)
    );

    board_regs board_regs_i (
        .sysclk             (sysclk),
        .reset              (reset),
        .access             (access),
        .rdata              (rdata),
        .board_in           (board_in),
        .safety_amp_disable (safety_amp_disable),
        .safety             (safety),
        .wr_strobe          (wr_strobe),
        .wdog_period        (wdog_period),
        .sw_disable         (sw_disable),
        .dout               (board_out.dout),
        .pwr_enable         (board_out.pwr_enable),
        .relay_on           (board_out.relay_on)
    );

    amp_safety amp_safety_i (
        .sysclk      (sysclk),
        .reset       (reset),
        .wr_strobe   (wr_strobe),
        .wdog_period (wdog_period),
        .mv_good     (board_in.mv_good),
        .sw_disable  (sw_disable),
        .safety      (safety),
        .amp_disable (board_out.amp_disable)
    );

endmodule

`default_nettype wire

// ==== verification/board_ctrl_tb.sv ====
/*
 * testbench for the board parameter block driven by a trace file
 * host handshake driver, pin driver, value checker, cycle timeout
 */

`timescale 1ns/1ns
`default_nettype none

module board_ctrl_tb;
    import host_bus_pkg::*;
    import board_reg_pkg::*;

    localparam int MAX_RECS        = 128;
    localparam int HS_CYCLES       = 12;   // generous bound for one handshake
    localparam int RST_CYCLES      = 16;
    localparam int ACK_RISE_CYCLES = 4;    // negedges from req rise to ack high
    localparam int ACK_FALL_CYCLES = 2;    // negedges from req drop to ack low

    logic        sysclk;
    logic        reset;
    logic        host_req;
    host_req_t   host_cmd;
    logic        host_ack;
    logic [31:0] host_rdata;
    board_in_t   board_in;
    logic [3:0]  safety_amp_disable;
    board_out_t  board_out;

    // trace held in memory with up to 10 fields per record
    logic [7:0]  rec_kind [MAX_RECS];
    logic [31:0] rec_f    [MAX_RECS][10];
    int          num_recs;
    int          max_idle;
    int          cycle_limit;   // 0 until the trace is loaded
    int          cycle_count;
    int          errors;
    int          checks;
    bit          timed_out;

    board_ctrl_top board_ctrl_top_i (
        .sysclk             (sysclk),
        .reset              (reset),
        .host_req           (host_req),
        .host_cmd           (host_cmd),
        .host_ack           (host_ack),
        .host_rdata         (host_rdata),
        .board_in           (board_in),
        .safety_amp_disable (safety_amp_disable),
        .board_out          (board_out)
    );

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;   // 8 ns
    end

    // ------------------------------------------------------------
    // checking and end of run
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // trace loading
    // ------------------------------------------------------------
    task automatic load_trace(output bit ok);
        int               fd;
        int               n;
        int               want;
        logic [7:0]       kind;
        logic [8*160-1:0] rest;
        logic [31:0]      f [10];
        fd = $fopen("verification/board_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verification/board_trace.txt");
            errors++;
        end else begin
            while (num_recs < MAX_RECS && $fscanf(fd, "%s", kind) == 1) begin
                want = 0;
                n    = 0;
                case (kind)
                    "#": n = $fgets(rest, fd);   // column notes
                    "W", "R": begin
                        want = 2;
                        n = $fscanf(fd, "%h %h", f[0], f[1]);
                    end
                    "P": begin
                        want = 10;
                        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                    f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    end
                    "I": begin
                        want = 5;
                        n = $fscanf(fd, "%d %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                    end
                    default: begin
                        $display("Unknown trace record kind '%c' after entry %0d",
                                 kind, num_recs);
                        errors++;
                        n = $fgets(rest, fd);
                    end
                endcase
                if (want != 0 && n != want) begin   // short line
                    $display("Trace record %0d of kind %c has too few fields", num_recs, kind);
                    errors++;
                end else if (want != 0) begin
                    rec_kind[num_recs] = kind;
                    rec_f[num_recs]    = f;
                    if (kind == "I" && int'(f[0]) > max_idle)
                        max_idle = int'(f[0]);
                    num_recs++;
                end
            end
            $fclose(fd);
        end
        ok = (errors == 0);
    endtask

    // ------------------------------------------------------------
    // drivers
    // ------------------------------------------------------------
    task automatic wait_ack(input logic level, output int waited);
        waited = 0;
        do begin
            @(negedge sysclk);   // sample mid cycle
            waited++;
        end while (host_ack !== level);
    endtask

    // full four-phase handshake
    task automatic host_access(input logic wr, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rd);
        int waited;
        @(posedge sysclk);
        host_cmd <= '{wr: wr, addr: addr, wdata: wdata};
        host_req <= 1'b1;
        wait_ack(1'b1, waited);
        check_value("host_ack rise cycles", 32'(waited), 32'(ACK_RISE_CYCLES));
        rd = host_rdata;   // held while ack high
        @(posedge sysclk);
        host_req <= 1'b0;
        wait_ack(1'b0, waited);
        check_value("host_ack fall cycles", 32'(waited), 32'(ACK_FALL_CYCLES));
    endtask

    task automatic apply_pins(input int i);
        @(posedge sysclk);
        board_in <= '{neg_limit: rec_f[i][0][3:0], pos_limit: rec_f[i][1][3:0],
                      home: rec_f[i][2][3:0], fault: rec_f[i][3][3:0],
                      relay: rec_f[i][4][0], mv_good: rec_f[i][5][0],
                      v_fault: rec_f[i][6][0], board_id: rec_f[i][7][3:0],
                      temp_sense: rec_f[i][8][15:0]};
        safety_amp_disable <= rec_f[i][9][3:0];
    endtask

    task automatic idle_and_check(input int i);
        repeat (rec_f[i][0]) @(posedge sysclk);
        @(negedge sysclk);
        check_value("board_out.amp_disable", 32'(board_out.amp_disable), rec_f[i][1]);
        check_value("board_out.dout", 32'(board_out.dout), rec_f[i][2]);
        check_value("board_out.pwr_enable", 32'(board_out.pwr_enable), rec_f[i][3]);
        check_value("board_out.relay_on", 32'(board_out.relay_on), rec_f[i][4]);
    endtask

    task automatic run_trace();
        logic [31:0] rd;
        for (int i = 0; i < num_recs; i++) begin
            case (rec_kind[i])
                "W": host_access(1'b1, rec_f[i][0][7:0], rec_f[i][1], rd);
                "R": begin
                    host_access(1'b0, rec_f[i][0][7:0], 32'd0, rd);
                    check_value($sformatf("host_rdata @ %h", rec_f[i][0][7:0]), rd,
                                rec_f[i][1]);
                end
                "P": apply_pins(i);
                default: idle_and_check(i);
            endcase
        end
    endtask

    // ------------------------------------------------------------
    // main sequence and timeout
    // ------------------------------------------------------------
    initial begin : main
        bit ok;
        host_req           = 1'b0;
        host_cmd           = '0;
        board_in           = '0;
        safety_amp_disable = '0;
        reset              = 1'b0;
        load_trace(ok);
        if (ok)
            cycle_limit = num_recs * (max_idle + HS_CYCLES) + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge sysclk);
        reset <= 1'b1;
        if (ok)
            run_trace();
        finish_run();
    end

    initial begin : timeout_guard
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge sysclk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the trace did not complete", cycle_count);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

`default_nettype wire

// ==== verification/board_trace.txt ====
# W addr data | R addr expected | I cycles(dec) amp_disable dout pwr_enable relay_on
# P neg_limit pos_limit home fault relay mv_good v_fault board_id temp_sense safety
I 4 f 0 0 0
R 04 514c4131
R 07 00000003
W 01 abcd1234
R 01 00001234
W 02 5a5aa5a5
R 02 0000a5a5
W 04 ffffffff
R 04 514c4131
R 08 00000000
R 20 00000000
W 06 00000305
R 06 00000001
W 06 00000c0f
R 06 0000000d
W 00 00010000
I 0 f d 0 0
W 00 00030000
I 0 f d 0 1
R 00 40030000
R 03 0000ffff
P 3 5 9 6 1 0 1 a 1234 0
R 05 00001234
R 0a 0001d359
R 00 4a010600
W 00 00000f0f
R 0f 0000000f
W 00 000c0000
P 3 5 9 6 1 1 1 a 1234 0
W 00 00000f05
I 0 f d 1 1
I 40 a d 1 1
R 0f 0000000a
R 00 4a0d0605
P 3 5 9 6 1 0 1 a 1234 0
I 0 f d 1 1
P 3 5 9 6 1 1 1 a 1234 0
I 40 a d 1 1
W 03 00000002
R 03 00000002
I 20 f d 1 1
R 0e 0000000f
R 00 4a8d0600
W 03 00000000
R 00 4a0d0600
W 00 00000f0f
I 2 0 d 1 1
P 3 5 9 6 1 1 1 a 1234 3
R 0b 00000003
R 00 4a0d063c
P 3 5 9 6 1 1 1 a 1234 0
I 2 3 d 1 1
R 0f 00000003
W 00 00080000
I 2 f d 0 1
W 00 00020000
W 06 00000100
I 0 f c 0 0
R 06 0000000c
R 0a 0001c359

// ==== vlog.f ====
+incdir+rtl
rtl/host_bus_pkg.sv
rtl/board_reg_pkg.sv
rtl/host_bus_port.sv
rtl/board_regs.sv
rtl/amp_safety.sv
rtl/board_ctrl_top.sv
verification/board_ctrl_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = board_ctrl_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
PASS_MSG   = Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
